/* ddr3_controller.f */
+incdir+src
src/ddr3_types_pkg.sv
src/ddr3_cmd_pkg.sv
src/ddr3_clock_gen.sv
src/ddr3_init_sequencer.sv
src/ddr3_refresh_credit.sv
src/ddr3_command_scheduler.sv
src/ddr3_data_path.sv
src/ddr3_controller.sv
testbench/ddr3_dram_model.sv
testbench/tb_ddr3_controller.sv

/* run_sim.sh */
#!/bin/sh
# builds the DDR3 controller testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f ddr3_controller.f \
	--top-module tb_ddr3_controller -o tb_ddr3_controller > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ddr3_controller > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -qx "tests failed" sim.log && exit 1
grep -qx "all tests passed" sim.log || exit 1
exit 0

/* testbench/ddr3_input.txt */
# op (w write, r read)  address (hex, bank in bits 17:15)  write data  expected read data
# the expected column is only checked on reads
w 00012 a5a5 0000
w 08123 1234 0000
w 1c3ff beef 0000
r 00012 0000 a5a5
r 08123 0000 1234
r 1c3ff 0000 beef
r 10055 0000 0000
w 08123 5678 0000
r 08123 0000 5678

/* testbench/tb_ddr3_controller.sv */
// testbench for the DDR3 controller
// checks power-up order, init commands and the first refresh burst, then runs
// Wishbone accesses from the input file plus random ones against the DRAM model
`timescale 1ns/1ps
`include "ddr3_params.svh"

module tb_ddr3_controller;

	localparam logic [2:0] C_MRS = 3'b000;  // JEDEC RAS#, CAS#, WE# patterns
	localparam logic [2:0] C_REF = 3'b001;
	localparam logic [2:0] C_PRE = 3'b010;
	localparam logic [2:0] C_ACT = 3'b011;
	localparam logic [2:0] C_WR = 3'b100;
	localparam logic [2:0] C_RD = 3'b101;
	localparam logic [2:0] C_ZQC = 3'b110;
	localparam int N_RANDOM = 2;  // random write and read pairs after the file
	localparam int INIT_TICKS = 300;

	logic clk, reset, wb_cyc, wb_stb, wb_we;
	ddr3_types_pkg::user_addr_t wb_adr;
	ddr3_types_pkg::dq_t wb_dat, o_wb_dat, o_dq, i_dq, model_dq;
	logic o_wb_ack, o_ck, o_ck_n, o_cke, o_cs_n, o_ras_n, o_cas_n, o_we_n, o_reset_n;
	ddr3_types_pkg::bank_t o_bank;
	ddr3_types_pkg::row_t o_addr;
	logic o_dq_oe, o_dqs, o_dqs_n, o_dqs_oe, o_dm, model_dqs, model_dqs_n;
	logic [2:0] ev_cmd [$];  // one entry per command seen on the pins
	ddr3_types_pkg::bank_t ev_bank [$];
	ddr3_types_pkg::row_t ev_addr [$];
	logic [2:0] prev_cmd;
	ddr3_types_pkg::bank_t prev_bank;
	ddr3_types_pkg::row_t prev_addr;
	logic prev_valid, loaded;
	logic ck_last;  // CK as it was one clk earlier
	int ck_count, quiet_ck, ack_count, n_access, n_total, mismatches, failures;

	ddr3_controller i_ddr3_controller (.clk(clk), .reset(reset), .i_wb_cyc(wb_cyc),
		.i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_adr(wb_adr), .i_wb_dat(wb_dat),
		.o_wb_ack(o_wb_ack), .o_wb_dat(o_wb_dat), .o_ck(o_ck), .o_ck_n(o_ck_n),
		.o_cke(o_cke), .o_cs_n(o_cs_n), .o_ras_n(o_ras_n), .o_cas_n(o_cas_n),
		.o_we_n(o_we_n), .o_reset_n(o_reset_n), .o_bank(o_bank), .o_addr(o_addr),
		.o_dq(o_dq), .o_dq_oe(o_dq_oe), .i_dq(i_dq), .o_dqs(o_dqs), .o_dqs_n(o_dqs_n),
		.o_dqs_oe(o_dqs_oe), .i_dqs(o_dqs_oe ? o_dqs : model_dqs),
		.i_dqs_n(o_dqs_oe ? o_dqs_n : model_dqs_n), .o_dm(o_dm));

	ddr3_dram_model u_dram (.i_ck(o_ck), .i_cs_n(o_cs_n), .i_ras_n(o_ras_n),
		.i_cas_n(o_cas_n), .i_we_n(o_we_n), .i_bank(o_bank), .i_addr(o_addr), .i_dq(o_dq),
		.i_dm(o_dm), .o_dq(model_dq), .o_dqs(model_dqs), .o_dqs_n(model_dqs_n));

	assign i_dq = o_dq_oe ? o_dq : model_dq;  // stands in for the pad buffer

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		mismatches++;
		$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("ERROR time=%0t %s", $time, what);
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	// one Wishbone classic access, held until ack
	task automatic run_access(input logic we, input ddr3_types_pkg::user_addr_t adr,
		input ddr3_types_pkg::dq_t dat, input ddr3_types_pkg::dq_t exp);
		@(posedge clk);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat = dat;
		n_access++;
		do
			@(posedge clk);
		while (!o_wb_ack);
		if (!we && o_wb_dat !== exp)
			report_mismatch("o_wb_dat", exp, o_wb_dat);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		if (o_wb_ack)
			ack_count++;

	// clock pair and write strobe pins, settled halfway through each clk
	always @(negedge clk)
	begin
		if (o_ck_n !== !o_ck)
			report_mismatch("o_ck_n", !o_ck, o_ck_n);
		if (o_dqs_oe && o_dqs !== ck_last)
			report_mismatch("o_dqs", ck_last, o_dqs);  // the strobe lags CK by one clk
		if (o_dqs_oe && o_dqs_n !== !o_dqs)
			report_mismatch("o_dqs_n", !o_dqs, o_dqs_n);
		if (o_dq_oe !== o_dm)
			report_mismatch("o_dq_oe", o_dm, o_dq_oe);  // DQ is driven exactly on DM beats
		if (o_dm && !o_dqs_oe)
			report_failure("DM high while the write strobe is off");
		ck_last = o_ck;
	end

	// command monitor, the pins are stable at each rising CK
	always @(posedge o_ck)
	begin
		ck_count++;
		if (o_cs_n)
		begin
			quiet_ck++;
			prev_valid = 1'b0;
		end
		else
		begin
			quiet_ck = 0;
			if (!prev_valid || {o_ras_n, o_cas_n, o_we_n} != prev_cmd ||
				o_bank != prev_bank || o_addr != prev_addr)
			begin
				ev_cmd.push_back({o_ras_n, o_cas_n, o_we_n});
				ev_bank.push_back(o_bank);
				ev_addr.push_back(o_addr);
				if ({o_ras_n, o_cas_n, o_we_n} == C_ACT)
				begin
					if (!wb_cyc)
						report_failure("ACT issued while cyc was low");
					if (o_bank != wb_adr[17:15])
						report_mismatch("o_bank", wb_adr[17:15], o_bank);
					if (o_addr != wb_adr[14:0])
						report_mismatch("o_addr", wb_adr[14:0], o_addr);
				end
				// A12 high keeps the full burst and A10 high asks for auto-precharge
				if (({o_ras_n, o_cas_n, o_we_n} == C_WR ||
					{o_ras_n, o_cas_n, o_we_n} == C_RD) &&
					o_addr != {2'b00, 1'b1, 1'b0, 1'b1, wb_adr[9:0]})
					report_mismatch("o_addr", {2'b00, 1'b1, 1'b0, 1'b1, wb_adr[9:0]},
						o_addr);
			end
			prev_valid = 1'b1;
			prev_cmd = {o_ras_n, o_cas_n, o_we_n};
			prev_bank = o_bank;
			prev_addr = o_addr;
		end
		if (o_dm && o_dq != wb_dat)
			report_mismatch("o_dq", wb_dat, o_dq);  // DM high marks a written beat
	end

	initial
	begin
		wait (loaded);
		#((INIT_TICKS + 400 * n_total) * 4 * 8);
		report_failure("timeout, the run did not finish in time");
		finish_run();
	end

	initial
	begin
		int fd, r, i, seed, refs, exp_refs;
		string line;
		logic [7:0] op;
		logic [31:0] a, d, e;
		logic fw [$];
		logic [31:0] fa [$], fd_q [$], fe [$];
		ddr3_types_pkg::user_addr_t radr;
		ddr3_types_pkg::dq_t rdat;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat = '0;
		prev_valid = 1'b0;
		loaded = 1'b0;
		ck_last = 1'b0;
		ck_count = 0;
		quiet_ck = 0;
		ack_count = 0;
		n_access = 0;
		mismatches = 0;
		failures = 0;
		seed = 4;
		fd = $fopen("testbench/ddr3_input.txt", "r");
		if (fd == 0)
			report_failure("cannot open testbench/ddr3_input.txt");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				r = $sscanf(line, "%s %h %h %h", op, a, d, e);
				if (r == 4)
				begin
					fw.push_back(op == "w");
					fa.push_back(a);
					fd_q.push_back(d);
					fe.push_back(e);
				end
			end
			$fclose(fd);
		end
		n_total = fw.size() + 2 * N_RANDOM;
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		ck_count = 0;  // refresh credit loss is timed from here
		if (o_reset_n !== 1'b0)
			report_mismatch("o_reset_n", 0, o_reset_n);
		if (o_cke !== 1'b0)
			report_mismatch("o_cke", 0, o_cke);
		if (o_cs_n !== 1'b1)
			report_mismatch("o_cs_n", 1, o_cs_n);
		if (o_wb_ack !== 1'b0)
			report_mismatch("o_wb_ack", 0, o_wb_ack);
		if (o_dq_oe !== 1'b0 || o_dqs_oe !== 1'b0 || o_dm !== 1'b0)
			report_failure("output enables or DM active after reset");
		if (o_wb_dat !== '0)
			report_mismatch("o_wb_dat", 0, o_wb_dat);
		wait (o_reset_n);
		@(negedge clk);
		if (o_cke)
			report_failure("CKE rose no later than RESET#");
		// power-up and the first refresh burst run with the bus idle
		do
			@(negedge clk);
		while (ev_cmd.size() < 5 || quiet_ck < 16);
		for (i = 0; i < 4; i++)
		begin
			if (ev_cmd[i] != C_MRS)
				report_mismatch("mrs cmd", C_MRS, ev_cmd[i]);
		end
		if (ev_bank[0] != 2)
			report_mismatch("o_bank", 2, ev_bank[0]);
		if (ev_bank[1] != 3)
			report_mismatch("o_bank", 3, ev_bank[1]);
		if (ev_bank[2] != 1)
			report_mismatch("o_bank", 1, ev_bank[2]);
		if (ev_bank[3] != 0)
			report_mismatch("o_bank", 0, ev_bank[3]);
		if (ev_addr[0] != `DDR3_MR2_VALUE)
			report_mismatch("o_addr", `DDR3_MR2_VALUE, ev_addr[0]);
		if (ev_addr[1] != `DDR3_MR3_VALUE)
			report_mismatch("o_addr", `DDR3_MR3_VALUE, ev_addr[1]);
		if (ev_addr[2] != `DDR3_MR1_VALUE)
			report_mismatch("o_addr", `DDR3_MR1_VALUE, ev_addr[2]);
		if (ev_addr[3] != `DDR3_MR0_VALUE)
			report_mismatch("o_addr", `DDR3_MR0_VALUE, ev_addr[3]);
		if (ev_cmd[4] != C_ZQC || !ev_addr[4][10])
			report_failure("ZQ calibration with A10 high missing after MR0");
		refs = 0;
		for (i = 5; i < ev_cmd.size(); i++)
		begin
			if (ev_cmd[i] == C_REF)
			begin
				refs++;
				if (ev_cmd[i-1] != C_PRE || ev_addr[i-1][10])
					report_failure("REF not preceded by PRE with A10 low");
			end
			else if (ev_cmd[i] != C_PRE)
				report_failure("unexpected command in the first refresh burst");
		end
		// credit fills to the maximum, plus one for each tREFI already gone
		exp_refs = `DDR3_REFRESH_MAX + ck_count / `DDR3_T_REFI;
		if (refs != exp_refs)
			report_mismatch("refresh count", exp_refs, refs);
		// stb without cyc is no request, the monitor flags any ACT it starts
		@(posedge clk);
		#1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		repeat (32) @(posedge clk);
		#1;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		for (i = 0; i < fw.size(); i++)
		begin
			run_access(fw[i], fa[i], fd_q[i], fe[i]);
			repeat ($unsigned($random(seed)) % 16) @(posedge clk);
		end
		for (i = 0; i < N_RANDOM; i++)
		begin
			radr = $random(seed);
			rdat = $random(seed);
			run_access(1'b1, radr, rdat, '0);
			run_access(1'b0, radr, '0, rdat);
		end
		repeat (32) @(posedge clk);
		if (ack_count != n_access)
			report_mismatch("ack count", n_access, ack_count);
		finish_run();
	end

endmodule

/* testbench/ddr3_dram_model.sv */
// behavioural DDR3 device for the controller testbench
// decodes commands on rising CK, stores words written while DM is high and
// answers a read after the read latency with DQS toggling at CK rate
`timescale 1ns/1ps
`include "ddr3_params.svh"

module ddr3_dram_model
(
	input  logic i_ck,
	input  logic i_cs_n,
	input  logic i_ras_n,
	input  logic i_cas_n,
	input  logic i_we_n,
	input  ddr3_types_pkg::bank_t i_bank,
	input  ddr3_types_pkg::row_t i_addr,
	input  ddr3_types_pkg::dq_t i_dq,
	input  logic i_dm,
	output ddr3_types_pkg::dq_t o_dq,
	output logic o_dqs,
	output logic o_dqs_n
);

	localparam logic [2:0] CMD_WR = 3'b100;  // RAS# high, CAS# low, WE# low
	localparam logic [2:0] CMD_RD = 3'b101;

	ddr3_types_pkg::dq_t mem [logic [12:0]];  // keyed by bank and column
	logic [12:0] wr_key;
	logic [12:0] rd_key;
	logic [2:0] cmd;
	logic rd_seen;  // RD is held for several CK, only its first edge counts
	logic drive;
	int rd_wait;
	int burst_left;

	initial
	begin
		o_dq = '0;
		drive = 1'b0;
		rd_seen = 1'b0;
		rd_wait = 0;
		burst_left = 0;
		wr_key = '0;
		rd_key = '0;
	end

	// the strobe pair follows CK while the burst is driven and sits low otherwise
	assign o_dqs = drive & i_ck;
	assign o_dqs_n = drive & ~i_ck;

	always @(posedge i_ck)
	begin
		cmd = {i_ras_n, i_cas_n, i_we_n};
		if (i_dm)
			mem[wr_key] = i_dq;  // the same word is written on every beat
		if (drive)
		begin
			burst_left = burst_left - 1;
			if (burst_left == 0)
				drive = 1'b0;
		end
		if (rd_wait > 0)
		begin
			rd_wait = rd_wait - 1;
			if (rd_wait == 0)
			begin
				drive = 1'b1;
				burst_left = `DDR3_T_BURST / 2;  // two beats per CK
				o_dq = mem.exists(rd_key) ? mem[rd_key] : '0;
			end
		end
		if (!i_cs_n && cmd == CMD_WR)
			wr_key = {i_bank, i_addr[9:0]};
		if (!i_cs_n && cmd == CMD_RD && !rd_seen)
		begin
			rd_key = {i_bank, i_addr[9:0]};
			rd_wait = `DDR3_T_RL;
		end
		rd_seen = !i_cs_n && cmd == CMD_RD;
	end

endmodule

/* src/ddr3_controller.sv */
// DDR3 controller top level
// Wishbone classic slave on the user side, one x16 DLL-off device on the other,
// with DQ and DQS split into output, enable and input for the pad buffer
`timescale 1ns/1ps

module ddr3_controller
(
	input  logic clk,
	input  logic reset,
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  ddr3_types_pkg::user_addr_t i_wb_adr,
	input  ddr3_types_pkg::dq_t i_wb_dat,
	output logic o_wb_ack,
	output ddr3_types_pkg::dq_t o_wb_dat,
	output logic o_ck,
	output logic o_ck_n,
	output logic o_cke,
	output logic o_cs_n,
	output logic o_ras_n,
	output logic o_cas_n,
	output logic o_we_n,
	output logic o_reset_n,
	output ddr3_types_pkg::bank_t o_bank,
	output ddr3_types_pkg::row_t o_addr,
	output ddr3_types_pkg::dq_t o_dq,
	output logic o_dq_oe,
	input  ddr3_types_pkg::dq_t i_dq,
	output logic o_dqs,  // one strobe pair serves both bytes
	output logic o_dqs_n,
	output logic o_dqs_oe,
	input  logic i_dqs,
	input  logic i_dqs_n,
	output logic o_dm
);

	logic tick;
	logic dqs90;
	logic init_done;
	ddr3_cmd_pkg::cmd_t init_cmd;
	ddr3_types_pkg::bank_t init_bank;
	ddr3_types_pkg::row_t init_addr;
	logic refresh_urgent;
	logic refresh_wanted;
	logic refresh_issued;
	logic write_strobe_en;
	logic write_data_en;
	logic read_window;

	ddr3_clock_gen u_clock_gen
	(
		.clk     (clk),
		.reset   (reset),
		.o_ck    (o_ck),
		.o_ck_n  (o_ck_n),
		.o_tick  (tick),
		.o_dqs90 (dqs90)
	);

	ddr3_init_sequencer u_init_sequencer
	(
		.clk         (clk),
		.reset       (reset),
		.i_tick      (tick),
		.o_reset_n   (o_reset_n),
		.o_cke       (o_cke),
		.o_cmd       (init_cmd),
		.o_bank      (init_bank),
		.o_addr      (init_addr),
		.o_init_done (init_done)
	);

	ddr3_refresh_credit u_refresh_credit
	(
		.clk              (clk),
		.reset            (reset),
		.i_tick           (tick),
		.i_refresh_issued (refresh_issued),
		.o_refresh_urgent (refresh_urgent),
		.o_refresh_wanted (refresh_wanted)
	);

	ddr3_command_scheduler u_command_scheduler
	(
		.clk               (clk),
		.reset             (reset),
		.i_tick            (tick),
		.i_wb_cyc          (i_wb_cyc),
		.i_wb_stb          (i_wb_stb),
		.i_wb_we           (i_wb_we),
		.i_wb_adr          (i_wb_adr),
		.i_init_done       (init_done),
		.i_init_cmd        (init_cmd),
		.i_init_bank       (init_bank),
		.i_init_addr       (init_addr),
		.i_refresh_urgent  (refresh_urgent),
		.i_refresh_wanted  (refresh_wanted),
		.o_cs_n            (o_cs_n),
		.o_ras_n           (o_ras_n),
		.o_cas_n           (o_cas_n),
		.o_we_n            (o_we_n),
		.o_bank            (o_bank),
		.o_addr            (o_addr),
		.o_wb_ack          (o_wb_ack),
		.o_refresh_issued  (refresh_issued),
		.o_write_strobe_en (write_strobe_en),
		.o_write_data_en   (write_data_en),
		.o_read_window     (read_window)
	);

	ddr3_data_path u_data_path
	(
		.clk               (clk),
		.reset             (reset),
		.i_dqs90           (dqs90),
		.i_write_strobe_en (write_strobe_en),
		.i_write_data_en   (write_data_en),
		.i_read_window     (read_window),
		.i_wb_dat          (i_wb_dat),
		.i_dq              (i_dq),
		.i_dqs             (i_dqs),
		.i_dqs_n           (i_dqs_n),
		.o_dq              (o_dq),
		.o_dq_oe           (o_dq_oe),
		.o_dqs             (o_dqs),
		.o_dqs_n           (o_dqs_n),
		.o_dqs_oe          (o_dqs_oe),
		.o_dm              (o_dm),
		.o_wb_dat          (o_wb_dat)
	);

endmodule

/* src/ddr3_data_path.sv */
// DDR3 data path
// drives the user word, the quarter-phase strobe and DM during a write burst
// and samples DQ a fixed two clk after each DQS edge of a read burst
`timescale 1ns/1ps

module ddr3_data_path
(
	input  logic clk,
	input  logic reset,
	input  logic i_dqs90,
	input  logic i_write_strobe_en,
	input  logic i_write_data_en,
	input  logic i_read_window,
	input  ddr3_types_pkg::dq_t i_wb_dat,
	input  ddr3_types_pkg::dq_t i_dq,
	input  logic i_dqs,
	input  logic i_dqs_n,
	output ddr3_types_pkg::dq_t o_dq,
	output logic o_dq_oe,
	output logic o_dqs,
	output logic o_dqs_n,
	output logic o_dqs_oe,
	output logic o_dm,
	output ddr3_types_pkg::dq_t o_wb_dat
);

	localparam logic [1:0] CAPTURE_DELAY = 2'd2;  // roughly the middle of a data eye

	logic dqs_q;
	logic dqs_edge;
	logic [1:0] capture_cnt;  // zero while no capture is pending

	// the same word goes out for the whole burst
	assign o_dq = i_wb_dat;
	assign o_dq_oe = i_write_data_en;
	assign o_dm = i_write_data_en;
	assign o_dqs = i_dqs90;  // centred on DQ by the quarter-phase shift
	assign o_dqs_n = ~i_dqs90;
	assign o_dqs_oe = i_write_strobe_en;

	// a change on DQS only counts while the pair is driven apart
	assign dqs_edge = i_read_window && (i_dqs != dqs_q) && (i_dqs != i_dqs_n);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dqs_q <= 1'b0;
			capture_cnt <= '0;
			o_wb_dat <= '0;
		end
		else
		begin
			dqs_q <= i_dqs;
			if (capture_cnt == CAPTURE_DELAY)
				o_wb_dat <= i_dq;
			// the next edge may come in the capture clk itself
			if (dqs_edge)
				capture_cnt <= 2'd1;
			else if (capture_cnt == CAPTURE_DELAY)
				capture_cnt <= '0;
			else if (capture_cnt != '0)
				capture_cnt <= capture_cnt + 1'b1;
		end
	end

endmodule

/* src/ddr3_command_scheduler.sv */
// DDR3 command scheduler
// passes the power-up commands through, then serves single Wishbone accesses as
// ACT plus WR or RD with auto-precharge, with PRE and REF slotted in by credit
`timescale 1ns/1ps
`include "ddr3_params.svh"

module ddr3_command_scheduler
(
	input  logic clk,
	input  logic reset,
	input  logic i_tick,
	input  logic i_wb_cyc,
	input  logic i_wb_stb,
	input  logic i_wb_we,
	input  ddr3_types_pkg::user_addr_t i_wb_adr,
	input  logic i_init_done,
	input  ddr3_cmd_pkg::cmd_t i_init_cmd,
	input  ddr3_types_pkg::bank_t i_init_bank,
	input  ddr3_types_pkg::row_t i_init_addr,
	input  logic i_refresh_urgent,
	input  logic i_refresh_wanted,
	output logic o_cs_n,
	output logic o_ras_n,
	output logic o_cas_n,
	output logic o_we_n,
	output ddr3_types_pkg::bank_t o_bank,
	output ddr3_types_pkg::row_t o_addr,
	output logic o_wb_ack,
	output logic o_refresh_issued,
	output logic o_write_strobe_en,
	output logic o_write_data_en,
	output logic o_read_window
);

	ddr3_cmd_pkg::sched_state_t state;
	ddr3_cmd_pkg::sched_state_t next_state;
	ddr3_types_pkg::wait_t wait_cnt;
	ddr3_types_pkg::wait_t state_len;
	ddr3_cmd_pkg::cmd_t cmd;
	ddr3_types_pkg::bank_t user_bank;
	ddr3_types_pkg::row_t user_row;
	ddr3_types_pkg::row_t user_col;
	logic request;
	logic state_end;  // last tick of the current state

	assign request = i_wb_cyc && i_wb_stb;  // address and data are read live until ack
	assign user_bank = i_wb_adr[`DDR3_BANK_BITS+`DDR3_ROW_BITS-1 -: `DDR3_BANK_BITS];
	assign user_row = i_wb_adr[`DDR3_ROW_BITS-1:0];

	// column word with auto-precharge on and a full burst of eight
	always_comb
	begin
		user_col = '0;
		user_col[`DDR3_COL_BITS-1:0] = i_wb_adr[`DDR3_COL_BITS-1:0];
		user_col[`DDR3_A10_BIT] = 1'b1;
		user_col[`DDR3_A12_BIT] = 1'b1;
	end

	always_comb
	begin
		next_state = state;
		state_len = ddr3_types_pkg::wait_t'(1);  // the waiting states decide every tick
		case (state)
			ddr3_cmd_pkg::WAIT_INIT:
				if (i_init_done)
					next_state = ddr3_cmd_pkg::IDLE;
			ddr3_cmd_pkg::IDLE:
				if (i_refresh_urgent)
					next_state = ddr3_cmd_pkg::PRECHARGE;
				else if (request)
					next_state = ddr3_cmd_pkg::ACTIVATE;
				else if (i_refresh_wanted)
					next_state = ddr3_cmd_pkg::PRECHARGE;  // only when the bus is quiet
			ddr3_cmd_pkg::ACTIVATE:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_RCD);
				next_state = i_wb_we ? ddr3_cmd_pkg::WRITE_CMD : ddr3_cmd_pkg::READ_CMD;
			end
			ddr3_cmd_pkg::WRITE_CMD:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_CWL);
				next_state = ddr3_cmd_pkg::WRITE_DATA;
			end
			ddr3_cmd_pkg::WRITE_DATA:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_BURST + `DDR3_T_WPST);
				next_state = ddr3_cmd_pkg::IDLE;
			end
			ddr3_cmd_pkg::READ_CMD:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_RL);
				next_state = ddr3_cmd_pkg::READ_DATA;
			end
			ddr3_cmd_pkg::READ_DATA:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_BURST + `DDR3_T_RPST);
				next_state = ddr3_cmd_pkg::IDLE;
			end
			ddr3_cmd_pkg::PRECHARGE:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_RP);
				next_state = ddr3_cmd_pkg::REFRESH;
			end
			ddr3_cmd_pkg::REFRESH:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_RFC);
				next_state = ddr3_cmd_pkg::IDLE;
			end
			default: next_state = ddr3_cmd_pkg::WAIT_INIT;
		endcase
	end

	assign state_end = i_tick && (wait_cnt == state_len - 1'b1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ddr3_cmd_pkg::WAIT_INIT;
			wait_cnt <= '0;
			o_wb_ack <= 1'b0;
			o_refresh_issued <= 1'b0;
		end
		else
		begin
			// both pulses land in the clk after the closing tick
			o_wb_ack <= state_end && (state == ddr3_cmd_pkg::WRITE_DATA ||
				state == ddr3_cmd_pkg::READ_DATA);
			o_refresh_issued <= state_end && (state == ddr3_cmd_pkg::PRECHARGE);
			if (state_end)
			begin
				state <= next_state;
				wait_cnt <= '0;
			end
			else if (i_tick)
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// every command stays on the pins for its whole state
	always_comb
	begin
		cmd = ddr3_cmd_pkg::NOP;
		o_bank = '0;
		o_addr = '0;  // PRE leaves A10 low and closes one bank only
		case (state)
			ddr3_cmd_pkg::WAIT_INIT:
			begin
				cmd = i_init_cmd;
				o_bank = i_init_bank;
				o_addr = i_init_addr;
			end
			ddr3_cmd_pkg::ACTIVATE:
			begin
				cmd = ddr3_cmd_pkg::ACT;
				o_bank = user_bank;
				o_addr = user_row;
			end
			ddr3_cmd_pkg::WRITE_CMD:
			begin
				cmd = ddr3_cmd_pkg::WR;
				o_bank = user_bank;
				o_addr = user_col;
			end
			ddr3_cmd_pkg::READ_CMD:
			begin
				cmd = ddr3_cmd_pkg::RD;
				o_bank = user_bank;
				o_addr = user_col;
			end
			ddr3_cmd_pkg::PRECHARGE: cmd = ddr3_cmd_pkg::PRE;
			ddr3_cmd_pkg::REFRESH: cmd = ddr3_cmd_pkg::REF;
			default: cmd = ddr3_cmd_pkg::NOP;
		endcase
	end

	assign {o_ras_n, o_cas_n, o_we_n} = cmd;
	assign o_cs_n = (cmd == ddr3_cmd_pkg::NOP);  // NOP goes out as a deselect

	// the strobe starts with the write preamble in the last WR ticks
	assign o_write_strobe_en = ((state == ddr3_cmd_pkg::WRITE_CMD) &&
		(wait_cnt >= ddr3_types_pkg::wait_t'(`DDR3_T_CWL - `DDR3_T_WPRE))) ||
		(state == ddr3_cmd_pkg::WRITE_DATA);
	assign o_write_data_en = (state == ddr3_cmd_pkg::WRITE_DATA);
	assign o_read_window = (state == ddr3_cmd_pkg::READ_DATA);

endmodule

/* src/ddr3_refresh_credit.sv */
// DDR3 refresh credit tracker
// counts refreshes issued ahead of time, loses one per tREFI and asks for
// refresh urgently when low or lazily when not yet full
`timescale 1ns/1ps
`include "ddr3_params.svh"

module ddr3_refresh_credit
(
	input  logic clk,
	input  logic reset,
	input  logic i_tick,
	input  logic i_refresh_issued,
	output logic o_refresh_urgent,
	output logic o_refresh_wanted
);

	ddr3_types_pkg::credit_t credit;  // starts empty so init is followed by a refresh burst
	ddr3_types_pkg::wait_t refi_cnt;
	logic refi_expired;

	assign refi_expired = i_tick && (refi_cnt == ddr3_types_pkg::wait_t'(`DDR3_T_REFI - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			refi_cnt <= '0;
			credit <= '0;
		end
		else
		begin
			if (i_tick)
				refi_cnt <= refi_expired ? '0 : refi_cnt + 1'b1;
			// a refresh landing on the expiry tick cancels it out
			if (i_refresh_issued && !refi_expired && credit != `DDR3_REFRESH_MAX)
				credit <= credit + 1'b1;
			else if (refi_expired && !i_refresh_issued && credit != '0)
				credit <= credit - 1'b1;  // saturates at zero
		end
	end

	assign o_refresh_urgent = (credit <= ddr3_types_pkg::credit_t'(`DDR3_REFRESH_URGENT));
	assign o_refresh_wanted = (credit < ddr3_types_pkg::credit_t'(`DDR3_REFRESH_MAX));

endmodule

/* src/ddr3_init_sequencer.sv */
// DDR3 power-up sequencer
// holds RESET# and then CKE low, waits tXPR, loads MR2, MR3, MR1 and MR0 in that
// order and finishes with a long ZQ calibration before handing over the bus
`timescale 1ns/1ps
`include "ddr3_params.svh"

module ddr3_init_sequencer
(
	input  logic clk,
	input  logic reset,
	input  logic i_tick,
	output logic o_reset_n,
	output logic o_cke,
	output ddr3_cmd_pkg::cmd_t o_cmd,
	output ddr3_types_pkg::bank_t o_bank,
	output ddr3_types_pkg::row_t o_addr,
	output logic o_init_done
);

	ddr3_cmd_pkg::init_state_t state;
	ddr3_cmd_pkg::init_state_t next_state;
	ddr3_types_pkg::wait_t wait_cnt;  // ticks spent in the current state
	ddr3_types_pkg::wait_t state_len;

	// length, successor and pin values of each step
	always_comb
	begin
		next_state = state;
		state_len = '1;
		o_cmd = ddr3_cmd_pkg::NOP;
		o_bank = '0;
		o_addr = '0;
		case (state)
			ddr3_cmd_pkg::RESET_ACTIVE:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_RESET_ACTIVE);
				next_state = ddr3_cmd_pkg::CKE_LOW;
			end
			ddr3_cmd_pkg::CKE_LOW:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_CKE_INACTIVE);
				next_state = ddr3_cmd_pkg::WAIT_XPR;
			end
			ddr3_cmd_pkg::WAIT_XPR:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_XPR);
				next_state = ddr3_cmd_pkg::MRS2;
			end
			ddr3_cmd_pkg::MRS2:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_MRD);
				next_state = ddr3_cmd_pkg::MRS3;
				o_cmd = ddr3_cmd_pkg::MRS;
				o_bank = ddr3_types_pkg::bank_t'(2);  // the bank pins select the register
				o_addr = ddr3_types_pkg::row_t'(`DDR3_MR2_VALUE);
			end
			ddr3_cmd_pkg::MRS3:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_MRD);
				next_state = ddr3_cmd_pkg::MRS1;
				o_cmd = ddr3_cmd_pkg::MRS;
				o_bank = ddr3_types_pkg::bank_t'(3);
				o_addr = ddr3_types_pkg::row_t'(`DDR3_MR3_VALUE);
			end
			ddr3_cmd_pkg::MRS1:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_MRD);
				next_state = ddr3_cmd_pkg::MRS0;
				o_cmd = ddr3_cmd_pkg::MRS;
				o_bank = ddr3_types_pkg::bank_t'(1);
				o_addr = ddr3_types_pkg::row_t'(`DDR3_MR1_VALUE);
			end
			ddr3_cmd_pkg::MRS0:
			begin
				// the last MRS is followed by a non-MRS command so it waits tMOD
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_MOD);
				next_state = ddr3_cmd_pkg::ZQ_CAL;
				o_cmd = ddr3_cmd_pkg::MRS;
				o_addr = ddr3_types_pkg::row_t'(`DDR3_MR0_VALUE);
			end
			ddr3_cmd_pkg::ZQ_CAL:
			begin
				state_len = ddr3_types_pkg::wait_t'(`DDR3_T_ZQINIT);
				next_state = ddr3_cmd_pkg::DONE;
				o_cmd = ddr3_cmd_pkg::ZQC;
				o_addr[`DDR3_A10_BIT] = 1'b1;  // A10 high asks for ZQCL
			end
			ddr3_cmd_pkg::DONE: next_state = ddr3_cmd_pkg::DONE;
			default: next_state = ddr3_cmd_pkg::RESET_ACTIVE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ddr3_cmd_pkg::RESET_ACTIVE;
			wait_cnt <= '0;
		end
		else if (i_tick && state != ddr3_cmd_pkg::DONE)
		begin
			if (wait_cnt == state_len - 1'b1)
			begin
				state <= next_state;
				wait_cnt <= '0;
			end
			else
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	assign o_reset_n = (state != ddr3_cmd_pkg::RESET_ACTIVE);
	assign o_cke = (state != ddr3_cmd_pkg::RESET_ACTIVE) && (state != ddr3_cmd_pkg::CKE_LOW);
	assign o_init_done = (state == ddr3_cmd_pkg::DONE);

endmodule

/* src/ddr3_clock_gen.sv */
// DDR3 clock generator
// divides clk into CK and CK#, makes the quarter-phase copy of CK that becomes
// the write strobe, and marks each rising edge of that copy with a one clk tick
`timescale 1ns/1ps
`include "ddr3_params.svh"

module ddr3_clock_gen
(
	input  logic clk,
	input  logic reset,
	output logic o_ck,
	output logic o_ck_n,
	output logic o_tick,
	output logic o_dqs90
);

	localparam int HALF_PERIOD = `DDR3_DIVIDE_RATIO / 2;  // clk cycles per CK level

	logic [$clog2(HALF_PERIOD+1)-1:0] half_cnt;
	logic ck;
	logic ck90;
	logic tick;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			half_cnt <= '0;
			ck <= 1'b0;
			ck90 <= 1'b0;
			tick <= 1'b0;
		end
		else
		begin
			if (half_cnt == HALF_PERIOD - 1)
			begin
				half_cnt <= '0;
				ck <= ~ck;  // toggles once per half period
			end
			else
				half_cnt <= half_cnt + 1'b1;
			ck90 <= ck;  // one clk late is a quarter of the CK period
			tick <= ck & ~ck90;  // lands on the first clk of ck90 high
		end
	end

	assign o_ck = ck;
	assign o_ck_n = ~ck;
	assign o_tick = tick;
	assign o_dqs90 = ck90;

endmodule

/* src/ddr3_cmd_pkg.sv */
// DDR3 command and state encodings
// the command enum is the RAS#, CAS#, WE# pin pattern, CS# is decoded from NOP
package ddr3_cmd_pkg;

	typedef enum logic [2:0]
	{
		MRS = 3'b000,
		REF = 3'b001,
		PRE = 3'b010,
		ACT = 3'b011,
		WR  = 3'b100,
		RD  = 3'b101,
		ZQC = 3'b110,  // long or short calibration is picked by A10
		NOP = 3'b111
	} cmd_t;

	// power-up steps in the order they run
	typedef enum logic [3:0]
	{
		RESET_ACTIVE, CKE_LOW, WAIT_XPR, MRS2, MRS3, MRS1, MRS0, ZQ_CAL, DONE
	} init_state_t;

	typedef enum logic [3:0]
	{
		WAIT_INIT, IDLE, ACTIVATE, WRITE_CMD, WRITE_DATA, READ_CMD, READ_DATA,
		PRECHARGE, REFRESH
	} sched_state_t;

endpackage

/* src/ddr3_types_pkg.sv */
// DDR3 controller vector types
// widths for the addresses, data words and counters passed between the blocks
`include "ddr3_params.svh"

package ddr3_types_pkg;

	typedef logic [`DDR3_ROW_BITS-1:0] row_t;  // dram address pins
	typedef logic [`DDR3_BANK_BITS-1:0] bank_t;

	// user address with the bank in the top bits and the row below
	typedef logic [`DDR3_BANK_BITS+`DDR3_ROW_BITS-1:0] user_addr_t;

	typedef logic [`DDR3_DQ_BITS-1:0] dq_t;
	typedef logic [15:0] wait_t;  // counts ticks
	typedef logic [3:0] credit_t;  // holds zero up to the maximum refresh credit

endpackage

/* src/ddr3_params.svh */
// DDR3 controller parameters
// widths, timing counts in ticks, mode register values and refresh credit limits
// for one x16 device in DLL-off mode, with timings shortened for simulation
`ifndef DDR3_PARAMS_SVH
`define DDR3_PARAMS_SVH

`define DDR3_ROW_BITS        15     // dram address pins
`define DDR3_BANK_BITS       3
`define DDR3_DQ_BITS         16     // x16 device
`define DDR3_COL_BITS        10     // column bits taken from the user address
`define DDR3_DIVIDE_RATIO    4      // clk cycles per CK period

`define DDR3_T_RESET_ACTIVE  20     // RESET# held low
`define DDR3_T_CKE_INACTIVE  50     // CKE held low after RESET# rises
`define DDR3_T_XPR           6      // CKE high to the first MRS
`define DDR3_T_MRD           4      // MRS to MRS
`define DDR3_T_MOD           12     // MRS to a non-MRS command
`define DDR3_T_ZQINIT        64     // ZQCL calibration time
`define DDR3_T_RCD           1
`define DDR3_T_RP            1
`define DDR3_T_RFC           6
`define DDR3_T_CWL           6      // only CWL of 6 works with the DLL off
`define DDR3_T_RL            6
`define DDR3_T_BURST         8
`define DDR3_T_WPRE          1
`define DDR3_T_WPST          1
`define DDR3_T_RPST          1
`define DDR3_T_REFI          200    // one refresh credit is lost per tREFI

`define DDR3_REFRESH_MAX     8      // the device can hold eight refreshes in advance
`define DDR3_REFRESH_URGENT  3      // at or below this credit refresh goes first

`define DDR3_MR0_VALUE       'h310  // BL8 fixed, sequential burst, write recovery and CL
`define DDR3_MR1_VALUE       3      // DLL disabled with the 34 ohm driver
`define DDR3_MR2_VALUE       0
`define DDR3_MR3_VALUE       0      // MPR disabled
`define DDR3_A10_BIT         10     // auto-precharge or precharge-all
`define DDR3_A12_BIT         12     // burst chop when low

`endif
